/* Bender.yml */
package:
  name: sad_trigger

sources:
  # rtl, package first
  - files:
      - logic/sad_pkg.sv
      - logic/sad_apb_regs.sv
      - logic/sad_sample_feed.sv
      - logic/sad_lane.sv
      - logic/sad_trigger_combine.sv
      - logic/sad_trigger_top.sv

  # testbench, top module sad_tb
  - target: test
    files:
      - dv/sad_tb.sv

/* dv/sad_tb.sv */
`timescale 1ns/1ns

module sad_tb;
    import sad_pkg::*;

    localparam int CLK_NS   = 20;
    localparam int RAND_LEN = 400;   // random samples in test 4
    localparam int SPLICES  = 2;     // patterns hidden in the random stream
    // samples streamed by tests 2 to 5
    localparam int TEST_SAMPLES = REF_SAMPLES + 2 * REF_SAMPLES
                                + RAND_LEN + SPLICES * REF_SAMPLES + 7 * REF_SAMPLES;
    localparam int WATCHDOG_NS  = TEST_SAMPLES * CLK_NS * 2 + 2000;
    localparam sad_sum_t EDGE_THR = 16'd40;  // threshold edge test
    localparam sad_sum_t RAND_THR = 16'd24;  // loose enough for +1 noise

    logic      adc_sampleclk;
    logic      reset;
    sample_t   adc_data;
    logic      active;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    logic      trigger;

    // reference model state
    sample_t   m_ref [REF_SAMPLES];   // what the testbench wrote
    sad_sum_t  m_thr;
    logic      m_mode;                // multiple triggers
    logic      m_fired;               // expected sticky status
    logic      m_active_q;
    logic      hit_q0;                // window matched, this edge
    logic      hit_q1;                // one cycle later, lane hit
    logic      exp_trigger;
    logic      clear_now;
    sample_t   hist [$];              // accepted samples since active rose
    apb_data_t exp_rdata;
    logic      exp_err;

    sample_t   pattern [REF_SAMPLES];
    int        errors = 0;
    int        errors_mark = 0;
    int        tests_run = 0;
    int        trig_count = 0;
    int        count_mark = 0;

    sad_trigger_top UUT (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .adc_data      (adc_data),
        .active        (active),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .trigger       (trigger)
    );

    initial adc_sampleclk = 1'b0;
    always #(CLK_NS / 2) adc_sampleclk = ~adc_sampleclk;

    assign clear_now = psel && penable && pwrite && (paddr == REG_STATUS);  // any status write

    // window sad per accepted sample, hit pipelined two cycles to the trigger
    always @(posedge adc_sampleclk) begin : window_model
        int unsigned sad;
        sad = 0;
        if (reset) begin
            m_active_q  <= 1'b0;
            hit_q0      <= 1'b0;
            hit_q1      <= 1'b0;
            exp_trigger <= 1'b0;
            m_fired     <= 1'b0;
            hist.delete();
        end else begin
            hit_q0 <= 1'b0;
            if (active) begin
                if (!m_active_q) hist.delete();  // fresh stream, old windows gone
                hist.push_back(adc_data);
                if (hist.size() > REF_SAMPLES) void'(hist.pop_front());
                if (hist.size() == REF_SAMPLES) begin
                    for (int j = 0; j < REF_SAMPLES; j++) begin
                        sad += (hist[j] > m_ref[j]) ? hist[j] - m_ref[j] : m_ref[j] - hist[j];
                    end
                    if (sad > 32'h0000_FFFF) sad = 32'h0000_FFFF;  // saturate like sad_sum_t
                    hit_q0 <= (sad <= m_thr);
                end
            end
            m_active_q  <= active;
            hit_q1      <= hit_q0;
            exp_trigger <= hit_q1 && (m_mode || !m_fired);
            if (!m_fired && hit_q1) m_fired <= 1'b1;
            else if (m_fired && clear_now) m_fired <= 1'b0;  // rearm
        end
    end

    // register map as the model sees it
    always_comb begin
        exp_rdata = '0;
        exp_err   = 1'b0;
        if (paddr[7:4] == 4'h1 && paddr[1:0] == 2'b00) begin
            exp_rdata = {m_ref[{paddr[3:2], 2'd3}], m_ref[{paddr[3:2], 2'd2}],
                         m_ref[{paddr[3:2], 2'd1}], m_ref[{paddr[3:2], 2'd0}]};
        end else begin
            case (paddr)
                REG_STATUS:    exp_rdata = apb_data_t'(m_fired);
                REG_THRESHOLD: exp_rdata = apb_data_t'(m_thr);
                REG_CONFIG:    exp_rdata = apb_data_t'(m_mode);
                REG_INFO:      exp_rdata = 32'h0000_0810;  // 8 bit samples, 16 of them
                default:       exp_err   = 1'b1;          // unmapped
            endcase
        end
        if (pwrite && paddr == REG_INFO) exp_err = 1'b1;  // read only word
    end

    always @(posedge adc_sampleclk) begin
        if (!reset && trigger) trig_count++;
    end

    task note_error(input string msg);
        errors++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    trigger_vs_model: assert property (
        @(posedge adc_sampleclk) disable iff (reset) trigger == exp_trigger
    ) else note_error($sformatf("trigger %0b, model %0b", $sampled(trigger),
                                $sampled(exp_trigger)));

    read_vs_model: assert property (
        @(posedge adc_sampleclk) disable iff (reset)
        (psel && penable && !pwrite) |-> (prdata == exp_rdata)
    ) else note_error($sformatf("read 0x%02h gave 0x%08h, model 0x%08h", $sampled(paddr),
                                $sampled(prdata), $sampled(exp_rdata)));

    slverr_vs_model: assert property (
        @(posedge adc_sampleclk) disable iff (reset)
        (psel && penable) |-> (pslverr == exp_err && pready)
    ) else note_error($sformatf("pslverr %0b at 0x%02h, model %0b", $sampled(pslverr),
                                $sampled(paddr), $sampled(exp_err)));

    // no error and no data outside an access phase
    quiet_outside_access: assert property (
        @(posedge adc_sampleclk) disable iff (reset)
        !(psel && penable) |-> (!pslverr && prdata == '0)
    ) else note_error($sformatf("pslverr %0b, prdata 0x%08h outside access phase",
                                $sampled(pslverr), $sampled(prdata)));

    // zero wait state write, model follows only legal targets
    task apb_write(input apb_addr_t addr, input apb_data_t data);
        @(posedge adc_sampleclk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge adc_sampleclk);
        penable <= 1'b1;
        @(posedge adc_sampleclk);  // access edge, write lands here
        if (addr == REG_THRESHOLD) m_thr <= data[SUM_BITS-1:0];
        else if (addr == REG_CONFIG) m_mode <= data[0];
        else if (addr[7:4] == 4'h1 && addr[1:0] == 2'b00) begin
            for (int k = 0; k < 4; k++) m_ref[addr[3:2] * 4 + k] <= data[k*8 +: 8];
        end
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task apb_read(input apb_addr_t addr);
        @(posedge adc_sampleclk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge adc_sampleclk);
        penable <= 1'b1;
        @(posedge adc_sampleclk);  // data checked by read_vs_model
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task push_sample(input sample_t d);
        @(posedge adc_sampleclk);
        adc_data <= d;
        active   <= 1'b1;
    endtask

    task stop_stream();
        @(posedge adc_sampleclk);
        active <= 1'b0;
    endtask

    task settle();
        repeat (5) @(posedge adc_sampleclk);  // covers the 2 cycle latency
    endtask

    task make_pattern();
        foreach (pattern[j]) pattern[j] = sample_t'($urandom_range(239, 16));  // room for offsets
    endtask

    task load_reference();
        for (int w = 0; w < REF_WORDS; w++) begin
            apb_write(apb_addr_t'(REG_REF_BASE + 4 * w), {pattern[4*w+3], pattern[4*w+2],
                                                          pattern[4*w+1], pattern[4*w]});
        end
    endtask

    task stream_pattern(input int reps);
        for (int r = 0; r < reps; r++) begin
            foreach (pattern[j]) push_sample(pattern[j]);
        end
    endtask

    // alternating offsets summing to EDGE_THR plus extra
    task stream_offset(input int extra);
        int delta;
        for (int j = 0; j < REF_SAMPLES; j++) begin
            delta = EDGE_THR / REF_SAMPLES + ((j < EDGE_THR % REF_SAMPLES) ? 1 : 0);
            if (j == 0) delta += extra;
            push_sample((j % 2) ? sample_t'(pattern[j] - delta) : sample_t'(pattern[j] + delta));
        end
    endtask

    task expect_triggers(input int n);
        assert (trig_count - count_mark == n)
        else note_error($sformatf("%0d trigger pulses, expected %0d", trig_count - count_mark, n));
    endtask

    task finish_test(input string name);
        tests_run++;
        $display("test %0d, %s: finished with %0d errors", tests_run, name, errors - errors_mark);
        errors_mark = errors;
    endtask

    initial begin
        void'($urandom(62));
        reset    = 1'b1;
        active   = 1'b0;
        adc_data = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        m_thr    = '0;
        m_mode   = 1'b0;
        foreach (m_ref[k]) m_ref[k] = '0;
        repeat (3) @(posedge adc_sampleclk);
        reset <= 1'b0;

        // reset values, readback, bad accesses
        apb_read(REG_STATUS);
        apb_read(REG_THRESHOLD);
        apb_read(REG_CONFIG);
        apb_read(REG_INFO);
        for (int w = 0; w < REF_WORDS; w++) apb_read(apb_addr_t'(REG_REF_BASE + 4 * w));
        apb_write(REG_THRESHOLD, 32'hABCD_1234);  // upper half dropped
        apb_read(REG_THRESHOLD);
        apb_write(REG_CONFIG, 32'h1);
        apb_read(REG_CONFIG);
        for (int w = 0; w < REF_WORDS; w++) begin
            apb_write(apb_addr_t'(REG_REF_BASE + 4 * w), apb_data_t'($urandom()));
            apb_read(apb_addr_t'(REG_REF_BASE + 4 * w));
        end
        apb_write(8'h24, 32'hFFFF_FFFF);
        apb_read(8'h40);
        apb_write(REG_INFO, 32'h0);
        apb_read(REG_INFO);
        apb_read(REG_THRESHOLD);
        apb_write(REG_CONFIG, 32'h0);
        finish_test("register reset and readback");

        make_pattern();
        load_reference();
        apb_write(REG_THRESHOLD, 32'h0);
        count_mark = trig_count;
        stream_pattern(1);
        stop_stream();
        settle();
        expect_triggers(1);
        finish_test("exact match");

        make_pattern();
        load_reference();
        apb_write(REG_THRESHOLD, apb_data_t'(EDGE_THR));
        apb_write(REG_STATUS, 32'h0);
        count_mark = trig_count;
        stream_offset(0);  // sad equals threshold
        stop_stream();
        settle();
        expect_triggers(1);
        apb_write(REG_STATUS, 32'h0);
        count_mark = trig_count;
        stream_offset(1);  // one over
        stop_stream();
        settle();
        expect_triggers(0);
        finish_test("threshold edge");

        make_pattern();
        load_reference();
        apb_write(REG_THRESHOLD, apb_data_t'(RAND_THR));
        apb_write(REG_CONFIG, 32'h1);
        count_mark = trig_count;
        for (int i = 0; i < RAND_LEN; i++) begin
            if (i == RAND_LEN / 3 || i == 2 * RAND_LEN / 3) begin
                foreach (pattern[j]) push_sample(sample_t'(pattern[j] + $urandom_range(1, 0)));
            end
            if ($urandom_range(15, 0) == 0) begin
                stop_stream();  // pause, next sample restarts all windows
                repeat ($urandom_range(2, 0)) @(posedge adc_sampleclk);
            end
            push_sample(sample_t'($urandom_range(255, 0)));
        end
        stop_stream();
        settle();
        assert (trig_count - count_mark >= SPLICES)
        else note_error($sformatf("%0d trigger pulses in random stream, expected at least %0d",
                                  trig_count - count_mark, SPLICES));
        finish_test("random stream");

        make_pattern();
        load_reference();
        apb_write(REG_THRESHOLD, 32'h0);
        apb_write(REG_CONFIG, 32'h0);
        apb_write(REG_STATUS, 32'h0);
        count_mark = trig_count;
        stream_pattern(3);  // single mode, only the first counts
        stop_stream();
        settle();
        expect_triggers(1);
        apb_read(REG_STATUS);
        apb_write(REG_STATUS, 32'h0);
        apb_read(REG_STATUS);
        count_mark = trig_count;
        stream_pattern(1);  // rearmed
        stop_stream();
        settle();
        expect_triggers(1);
        apb_write(REG_CONFIG, 32'h1);
        apb_write(REG_STATUS, 32'h0);
        count_mark = trig_count;
        stream_pattern(3);  // every repetition fires
        stop_stream();
        settle();
        expect_triggers(3);
        finish_test("single versus multiple triggers");

        settle();
        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // budget from the streamed sample counts
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* logic/sad_apb_regs.sv */
`timescale 1ns/1ns

module sad_apb_regs (
    input  logic                adc_sampleclk,
    input  logic                reset,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  sad_pkg::apb_addr_t  paddr,
    input  sad_pkg::apb_data_t  pwdata,
    input  logic                triggered,     // status from combiner
    output sad_pkg::apb_data_t  prdata,
    output logic                pready,
    output logic                pslverr,
    output sad_pkg::ref_bank_t  ref_bank,
    output sad_pkg::sad_sum_t   threshold,
    output logic                multiple_triggers,
    output logic                status_clear   // one cycle, on write to status
);
    import sad_pkg::*;

    logic      access;       // apb access phase
    logic      wr_access;
    logic      ref_hit;      // address inside the reference area
    logic      mapped;
    logic      info_write;   // illegal, info is read only
    logic      wr_ok;        // write that is allowed to land
    logic [1:0] ref_word;    // which reference word
    apb_data_t info_word;
    apb_data_t rd_mux;

    assign access    = psel && penable;
    assign wr_access = access && pwrite;

    // 0x10..0x1c, word aligned only
    assign ref_hit  = (paddr[APB_ADDR_BITS-1:4] == REG_REF_BASE[APB_ADDR_BITS-1:4])
                   && (paddr[1:0] == 2'b00);
    assign ref_word = paddr[3:2];

    assign mapped = (paddr == REG_STATUS) || (paddr == REG_THRESHOLD)
                 || (paddr == REG_CONFIG) || (paddr == REG_INFO) || ref_hit;

    assign info_write = pwrite && (paddr == REG_INFO);
    assign wr_ok      = wr_access && mapped && !info_write;

    assign pready  = 1'b1;                              // zero wait states always
    assign pslverr = access && (!mapped || info_write);  // bad address or info write

    // status clear is combinational so the combiner drops state on this same edge
    assign status_clear = wr_ok && (paddr == REG_STATUS);

    // geometry word: ref count low byte, sample width next byte
    assign info_word = apb_data_t'({8'(SAMPLE_BITS), 8'(REF_SAMPLES)});

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            threshold         <= '0;
            multiple_triggers <= 1'b0;
            ref_bank          <= '0;
        end else if (wr_ok) begin
            if (paddr == REG_THRESHOLD) begin
                threshold <= pwdata[SUM_BITS-1:0];
            end
            if (paddr == REG_CONFIG) begin
                multiple_triggers <= pwdata[0];
            end
            if (ref_hit) begin
                // lowest byte is the earliest sample of the word
                ref_bank[ref_word*APB_DATA_BITS +: APB_DATA_BITS] <= pwdata;
            end
        end
    end

    // readback mux
    always_comb begin
        rd_mux = '0;
        if (ref_hit) begin
            rd_mux = ref_bank[ref_word*APB_DATA_BITS +: APB_DATA_BITS];
        end else begin
            case (paddr)
                REG_STATUS:    rd_mux = apb_data_t'(triggered);
                REG_THRESHOLD: rd_mux = apb_data_t'(threshold);
                REG_CONFIG:    rd_mux = apb_data_t'(multiple_triggers);
                REG_INFO:      rd_mux = info_word;
                default:       rd_mux = '0;   // unmapped reads as zero
            endcase
        end
    end

    assign prdata = access ? rd_mux : '0;  // quiet outside access phase

    // a rejected access leaves the datapath settings untouched
    pslverr_no_effect: assert property (
        @(posedge adc_sampleclk) disable iff (reset)
        pslverr |=> ($stable(threshold) && $stable(ref_bank) && $stable(multiple_triggers))
    ) else $error("register changed on a rejected access");

endmodule

/* logic/sad_lane.sv */
`timescale 1ns/1ns

module sad_lane #(
    parameter int LANE = 0   // phase where this lane's window opens
) (
    input  logic               adc_sampleclk,
    input  logic               reset,
    input  sad_pkg::sample_t   sample,
    input  sad_pkg::phase_t    phase,
    input  logic               sample_valid,
    input  logic               window_restart,
    input  sad_pkg::ref_bank_t ref_bank,
    input  sad_pkg::sad_sum_t  threshold,
    output logic               lane_hit
);
    import sad_pkg::*;

    phase_t          lane_index;   // position inside this lane's window
    sample_t         ref_sample;
    sad_sum_t        abs_diff;
    sad_sum_t        acc;          // running sad
    logic [SUM_BITS:0] wide_sum;   // one extra bit to catch overflow
    sad_sum_t        sum_next;
    logic            filled;       // window started cleanly since restart

    assign lane_index = phase_t'(phase - phase_t'(LANE));
    assign ref_sample = ref_bank[lane_index*SAMPLE_BITS +: SAMPLE_BITS];

    // |sample - ref|, zero extended
    assign abs_diff = (sample > ref_sample) ? sad_sum_t'(sample - ref_sample)
                                            : sad_sum_t'(ref_sample - sample);

    assign wide_sum = {1'b0, acc} + {1'b0, abs_diff};
    assign sum_next = wide_sum[SUM_BITS] ? '1 : wide_sum[SUM_BITS-1:0];  // saturate

    // accumulator is payload only
    always_ff @(posedge adc_sampleclk) begin
        if (sample_valid) begin
            acc <= (lane_index == '0) ? abs_diff : sum_next;  // index 0 reopens
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            filled   <= 1'b0;
            lane_hit <= 1'b0;
        end else begin
            lane_hit <= 1'b0;
            if (sample_valid) begin
                if (lane_index == '0) begin
                    filled <= 1'b1;          // window begins here
                end else if (window_restart) begin
                    filled <= 1'b0;          // partial window thrown away
                end
                // a restart at index 15 never closes a stale window
                if ((lane_index == phase_t'(REF_SAMPLES - 1)) && filled && !window_restart) begin
                    lane_hit <= (sum_next <= threshold);
                end
            end
        end
    end

    // hit only ever follows the closing sample of this lane's window
    hit_after_close: assert property (
        @(posedge adc_sampleclk) disable iff (reset)
        $rose(lane_hit) |-> $past(sample_valid && (lane_index == phase_t'(REF_SAMPLES - 1)))
    ) else $error("lane %0d hit without a closing sample", LANE);

endmodule

/* logic/sad_pkg.sv */
package sad_pkg;

    // window geometry
    localparam int REF_SAMPLES   = 16;  // reference length, also lane count
    localparam int SAMPLE_BITS   = 8;   // adc word
    localparam int SUM_BITS      = 16;  // holds 16 x 255 with room to spare
    localparam int PHASE_BITS    = 4;   // counts 0..REF_SAMPLES-1

    // apb bus widths
    localparam int APB_ADDR_BITS = 8;
    localparam int APB_DATA_BITS = 32;

    typedef logic [SAMPLE_BITS-1:0]             sample_t;
    typedef logic [SUM_BITS-1:0]                sad_sum_t;
    typedef logic [PHASE_BITS-1:0]              phase_t;
    typedef logic [REF_SAMPLES*SAMPLE_BITS-1:0] ref_bank_t;  // sample k at bits 8k
    typedef logic [APB_ADDR_BITS-1:0]           apb_addr_t;
    typedef logic [APB_DATA_BITS-1:0]           apb_data_t;

    // register map, byte addresses
    localparam apb_addr_t REG_STATUS    = 8'h00;  // bit 0 triggered, write clears
    localparam apb_addr_t REG_THRESHOLD = 8'h04;  // low 16 bits
    localparam apb_addr_t REG_CONFIG    = 8'h08;  // bit 0 multiple_triggers
    localparam apb_addr_t REG_INFO      = 8'h0C;  // read only geometry word
    localparam apb_addr_t REG_REF_BASE  = 8'h10;  // four words up to 0x1c

    // words in the reference area
    localparam int REF_WORDS = (REF_SAMPLES * SAMPLE_BITS) / APB_DATA_BITS;

    // trigger combiner states
    typedef enum logic {
        TRIG_IDLE,   // armed, nothing since last clear
        TRIG_FIRED   // fired, status bit set
    } trig_state_e;

endpackage

/* logic/sad_sample_feed.sv */
`timescale 1ns/1ns

module sad_sample_feed (
    input  logic             adc_sampleclk,
    input  logic             reset,
    input  sad_pkg::sample_t adc_data,
    input  logic             active,          // take a sample on this edge
    output sad_pkg::sample_t sample,
    output sad_pkg::phase_t  phase,           // accepted count mod 16
    output logic             sample_valid,
    output logic             window_restart   // first sample after active rose
);
    import sad_pkg::*;

    logic active_q;   // active seen on the last edge
    logic restart;

    // low on the previous edge means this sample opens a fresh stream
    assign restart = active && !active_q;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            active_q       <= 1'b0;
            phase          <= '0;
            sample_valid   <= 1'b0;
            window_restart <= 1'b0;
        end else begin
            active_q       <= active;
            sample_valid   <= active;
            window_restart <= restart;
            if (restart) begin
                phase <= '0;                        // all windows start over
            end else if (active) begin
                phase <= phase_t'(phase + 1'b1);    // wraps at 16
            end
        end
    end

    // payload, no reset needed
    always_ff @(posedge adc_sampleclk) begin
        if (active) begin
            sample <= adc_data;
        end
    end

    // restart flag always travels with a real sample at phase 0
    restart_at_phase0: assert property (
        @(posedge adc_sampleclk) disable iff (reset)
        window_restart |-> (sample_valid && (phase == '0))
    ) else $error("window_restart without valid sample at phase 0");

endmodule

/* logic/sad_trigger_combine.sv */
`timescale 1ns/1ns

module sad_trigger_combine (
    input  logic                            adc_sampleclk,
    input  logic                            reset,
    input  logic [sad_pkg::REF_SAMPLES-1:0] lane_hit,
    input  logic                            multiple_triggers,  // fire on every hit
    input  logic                            status_clear,
    output logic                            trigger,
    output logic                            triggered           // sticky status
);
    import sad_pkg::*;

    trig_state_e state;
    trig_state_e state_next;
    logic        any_hit;
    logic        fire;

    assign any_hit = |lane_hit;

    // single mode only fires while still armed
    assign fire = any_hit && (multiple_triggers || (state == TRIG_IDLE));

    always_comb begin
        state_next = state;
        case (state)
            TRIG_IDLE: begin
                if (any_hit) begin
                    state_next = TRIG_FIRED;
                end
            end
            TRIG_FIRED: begin
                if (status_clear) begin
                    state_next = TRIG_IDLE;   // rearm
                end
            end
            default: state_next = TRIG_IDLE;
        endcase
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state   <= TRIG_IDLE;
            trigger <= 1'b0;
        end else begin
            state   <= state_next;
            trigger <= fire;   // one cycle pulse per qualifying hit
        end
    end

    assign triggered = (state == TRIG_FIRED);

    // in single mode a pulse must come from an armed combiner
    single_fire_once: assert property (
        @(posedge adc_sampleclk) disable iff (reset)
        trigger |-> $past((state == TRIG_IDLE) || multiple_triggers)
    ) else $error("trigger while fired with multiple_triggers clear");

endmodule

/* logic/sad_trigger_top.sv */
`timescale 1ns/1ns

module sad_trigger_top (
    input  logic                adc_sampleclk,
    input  logic                reset,
    input  sad_pkg::sample_t    adc_data,
    input  logic                active,
    // apb slave
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  sad_pkg::apb_addr_t  paddr,
    input  sad_pkg::apb_data_t  pwdata,
    output sad_pkg::apb_data_t  prdata,
    output logic                pready,
    output logic                pslverr,
    output logic                trigger
);
    import sad_pkg::*;

    // register side
    ref_bank_t ref_bank;
    sad_sum_t  threshold;
    logic      multiple_triggers;
    logic      status_clear;
    logic      triggered;

    // stream side
    sample_t   sample;
    phase_t    phase;
    logic      sample_valid;
    logic      window_restart;
    logic [REF_SAMPLES-1:0] lane_hit;   // one bit per lane

    sad_apb_regs u_regs (
        .adc_sampleclk     (adc_sampleclk),
        .reset             (reset),
        .psel              (psel),
        .penable           (penable),
        .pwrite            (pwrite),
        .paddr             (paddr),
        .pwdata            (pwdata),
        .triggered         (triggered),
        .prdata            (prdata),
        .pready            (pready),
        .pslverr           (pslverr),
        .ref_bank          (ref_bank),
        .threshold         (threshold),
        .multiple_triggers (multiple_triggers),
        .status_clear      (status_clear)
    );

    sad_sample_feed u_feed (
        .adc_sampleclk  (adc_sampleclk),
        .reset          (reset),
        .adc_data       (adc_data),
        .active         (active),
        .sample         (sample),
        .phase          (phase),
        .sample_valid   (sample_valid),
        .window_restart (window_restart)
    );

    // lane i owns the window opening at phase i
    for (genvar i = 0; i < REF_SAMPLES; i++) begin : gen_lane
        sad_lane #(
            .LANE (i)
        ) u_lane (
            .adc_sampleclk  (adc_sampleclk),
            .reset          (reset),
            .sample         (sample),
            .phase          (phase),
            .sample_valid   (sample_valid),
            .window_restart (window_restart),
            .ref_bank       (ref_bank),
            .threshold      (threshold),
            .lane_hit       (lane_hit[i])
        );
    end

    sad_trigger_combine u_combine (
        .adc_sampleclk     (adc_sampleclk),
        .reset             (reset),
        .lane_hit          (lane_hit),
        .multiple_triggers (multiple_triggers),
        .status_clear      (status_clear),
        .trigger           (trigger),
        .triggered         (triggered)
    );

endmodule

/* project.f */
logic/sad_pkg.sv
logic/sad_apb_regs.sv
logic/sad_sample_feed.sv
logic/sad_lane.sv
logic/sad_trigger_combine.sv
logic/sad_trigger_top.sv
dv/sad_tb.sv
